// ==== verilog/mmio_pkg.sv ====
/*
 * MMIO register manager shared types, register map, feature header
 * field layout and feature IDs
 */

package mmio_pkg;

    // MMIO address in 4-byte units; 64-bit registers sit at even addresses
    typedef logic [15:0] mmio_addr_t;

    // Host transaction tag, returned with each read response
    typedef logic [8:0] mmio_tid_t;

    // MMIO data word
    typedef logic [63:0] mmio_data_t;

    // Address translation mode and page table base (cache-line address)
    typedef logic [1:0]  vtp_mode_t;
    typedef logic [41:0] pt_addr_t;

    // 128-bit feature ID, read back as two words
    typedef logic [127:0] feature_id_t;

    // ======================================================================
    // Register map
    // ======================================================================

    // Each feature owns a 64-byte window; offsets below are in bytes
    localparam int FEATURE_CSR_BYTES = 64;

    localparam int CSR_DFH          = 0;
    localparam int CSR_ID_L         = 8;
    localparam int CSR_ID_H         = 16;
    localparam int CSR_VTP_MODE     = 24;
    localparam int CSR_VTP_PT_PADDR = 32;

    // Device feature header layout
    localparam logic [3:0] DFH_TYPE_BBB = 4'h2;
    localparam int DFH_TYPE_LSB  = 60;
    localparam int DFH_EOL_BIT   = 40;
    localparam int DFH_NEXT_LSB  = 16;
    localparam int DFH_NEXT_BITS = 24;

    typedef logic [DFH_NEXT_BITS-1:0] dfh_next_t;

    // Feature IDs
    localparam feature_id_t VTP_FEATURE_ID = 128'hc8a2982f_ff96_42bf_a705_45727f501901;
    localparam feature_id_t WRO_FEATURE_ID = 128'h56b06b48_9dd7_4004_a47e_0681b4207a6d;

    // Number of user-side scratch registers
    localparam int SCRATCH_COUNT = 4;

    // Builds a BBB feature header; every bit not named here stays zero
    function automatic mmio_data_t dfh_word(input logic eol, input dfh_next_t next);
        mmio_data_t w;
        w = '0;
        w[DFH_TYPE_LSB +: 4] = DFH_TYPE_BBB;
        w[DFH_EOL_BIT] = eol;
        w[DFH_NEXT_LSB +: DFH_NEXT_BITS] = next;
        return w;
    endfunction

endpackage

// ==== verilog/mmio_fifo.sv ====
/*
 * Synchronous circular-buffer FIFO with a typed payload and a
 * first-word-fall-through head
 */

`timescale 1ns/1ns

module mmio_fifo
#(
    parameter type payload_t = logic,
    parameter int  ENTRIES   = 2
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     enq_en,
    input  payload_t enq_data,
    input  logic     deq_en,
    output payload_t first,
    output logic     not_empty,
    output logic     not_full
);

    // A single-entry FIFO still needs one pointer bit
    localparam int PTR_BITS = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int CNT_BITS = $clog2(ENTRIES + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    payload_t mem [ENTRIES];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic do_enq;
    logic do_deq;

    // Pointers wrap at ENTRIES, which need not be a power of two
    function automatic ptr_t ptr_next(input ptr_t p);
        if (p == ptr_t'(ENTRIES - 1))
            return '0;
        return ptr_t'(p + 1'b1);
    endfunction

    assign not_empty = (count != '0);
    assign not_full  = (count != cnt_t'(ENTRIES));

    // A dequeue in the same cycle frees the slot, so a full FIFO may still enqueue
    assign do_deq = deq_en && not_empty;
    assign do_enq = enq_en && (not_full || do_deq);

    // Head is visible without a cycle of delay
    assign first = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_enq)
            mem[wr_ptr] <= enq_data;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_enq)
                wr_ptr <= ptr_next(wr_ptr);
            if (do_deq)
                rd_ptr <= ptr_next(rd_ptr);

            // Occupancy only moves when exactly one side acts
            case ({do_enq, do_deq})
                2'b10:   count <= cnt_t'(count + 1'b1);
                2'b01:   count <= cnt_t'(count - 1'b1);
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/afu_scratch_regs.sv ====
/*
 * User-side scratch register block, answers its own reads one cycle
 * after the request
 */

`timescale 1ns/1ns

module afu_scratch_regs
#(
    parameter int BASE_ADDR = 256
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  logic                req_write,
    input  mmio_pkg::mmio_addr_t req_addr,
    input  mmio_pkg::mmio_tid_t  req_tid,
    input  mmio_pkg::mmio_data_t req_data,
    output logic                afu_rsp_valid,
    output mmio_pkg::mmio_tid_t  afu_rsp_tid,
    output mmio_pkg::mmio_data_t afu_rsp_data
);

    import mmio_pkg::*;

    localparam int IDX_BITS = $clog2(SCRATCH_COUNT);

    // Each 64-bit register spans two 4-byte address units
    localparam mmio_addr_t SCRATCH_END = mmio_addr_t'(SCRATCH_COUNT * 2);
    localparam mmio_addr_t MGR_FIRST   = mmio_addr_t'(BASE_ADDR / 4);

    typedef logic [IDX_BITS-1:0] scratch_idx_t;

    mmio_data_t   scratch [SCRATCH_COUNT];
    logic         hit;
    scratch_idx_t idx;

    // The manager window always takes precedence over the scratch range
    assign hit = req_valid && !req_addr[0] &&
                 (req_addr < SCRATCH_END) && (req_addr < MGR_FIRST);
    assign idx = req_addr[IDX_BITS:1];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < SCRATCH_COUNT; i++)
                scratch[i] <= '0;
        end
        else if (hit && req_write)
        begin
            scratch[idx] <= req_data;
        end
    end

    // Read response valid, one cycle after the request
    always_ff @(posedge clk)
    begin
        if (reset)
            afu_rsp_valid <= 1'b0;
        else
            afu_rsp_valid <= hit && !req_write;
    end

    // Tag and data follow the valid strobe
    always_ff @(posedge clk)
    begin
        if (hit && !req_write)
        begin
            afu_rsp_tid  <= req_tid;
            afu_rsp_data <= scratch[idx];
        end
    end

endmodule

// ==== verilog/shim_csr_manager.sv ====
/*
 * Shim CSR manager: decodes host writes into shim configuration, queues
 * reads of the feature window and merges responses with the user block
 */

`timescale 1ns/1ns

module shim_csr_manager
#(
    parameter int BASE_ADDR  = 256,
    parameter int NEXT_ADDR  = 0,
    parameter int ENABLE_VTP = 0,
    parameter int ENABLE_WRO = 0
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  logic                req_write,
    input  mmio_pkg::mmio_addr_t req_addr,
    input  mmio_pkg::mmio_tid_t  req_tid,
    input  mmio_pkg::mmio_data_t req_data,
    input  logic                afu_rsp_valid,
    input  mmio_pkg::mmio_tid_t  afu_rsp_tid,
    input  mmio_pkg::mmio_data_t afu_rsp_data,
    output logic                rsp_valid,
    output mmio_pkg::mmio_tid_t  rsp_tid,
    output mmio_pkg::mmio_data_t rsp_data,
    output mmio_pkg::vtp_mode_t  vtp_mode,
    output mmio_pkg::pt_addr_t   pt_base,
    output logic                pt_base_valid
);

    import mmio_pkg::*;

    // Two features, translation first, then write ordering
    localparam int CSR_WINDOW_BYTES = 2 * FEATURE_CSR_BYTES;
    localparam int WRO_BASE_BYTES   = BASE_ADDR + FEATURE_CSR_BYTES;
    localparam int CSR_OFFSET_BITS  = $clog2(CSR_WINDOW_BYTES / 4);

    localparam mmio_addr_t WIN_FIRST = mmio_addr_t'(BASE_ADDR / 4);
    localparam mmio_addr_t WIN_END   = mmio_addr_t'((BASE_ADDR + CSR_WINDOW_BYTES) / 4);
    localparam mmio_addr_t MODE_ADDR = mmio_addr_t'((BASE_ADDR + CSR_VTP_MODE) / 4);
    localparam mmio_addr_t PT_ADDR   = mmio_addr_t'((BASE_ADDR + CSR_VTP_PT_PADDR) / 4);

    // Word offset from the start of the manager window
    typedef logic [CSR_OFFSET_BITS-1:0] csr_offset_t;
    typedef logic [CSR_OFFSET_BITS+$bits(mmio_tid_t)-1:0] req_entry_t;
    typedef logic [$bits(mmio_tid_t)+$bits(mmio_data_t)-1:0] rsp_entry_t;

    localparam csr_offset_t OFF_VTP_DFH  = csr_offset_t'(CSR_DFH / 4);
    localparam csr_offset_t OFF_VTP_ID_L = csr_offset_t'(CSR_ID_L / 4);
    localparam csr_offset_t OFF_VTP_ID_H = csr_offset_t'(CSR_ID_H / 4);
    localparam csr_offset_t OFF_VTP_MODE = csr_offset_t'(CSR_VTP_MODE / 4);
    localparam csr_offset_t OFF_VTP_PT   = csr_offset_t'(CSR_VTP_PT_PADDR / 4);
    localparam csr_offset_t OFF_WRO_DFH  = csr_offset_t'((FEATURE_CSR_BYTES + CSR_DFH) / 4);
    localparam csr_offset_t OFF_WRO_ID_L = csr_offset_t'((FEATURE_CSR_BYTES + CSR_ID_L) / 4);
    localparam csr_offset_t OFF_WRO_ID_H = csr_offset_t'((FEATURE_CSR_BYTES + CSR_ID_H) / 4);

    // ======================================================================
    // Request entry register
    // ======================================================================

    logic       req_valid_q;
    logic       req_write_q;
    mmio_addr_t req_addr_q;
    mmio_tid_t  req_tid_q;
    mmio_data_t req_data_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            req_valid_q <= 1'b0;
        else
            req_valid_q <= req_valid;
    end

    always_ff @(posedge clk)
    begin
        req_write_q <= req_write;
        req_addr_q  <= req_addr;
        req_tid_q   <= req_tid;
        req_data_q  <= req_data;
    end

    // ======================================================================
    // Host writes
    // ======================================================================

    logic       mode_wr_q;
    logic       pt_wr_q;
    mmio_data_t wr_data_q;

    // Second stage holds the address match, so outputs move two edges after sampling
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mode_wr_q <= 1'b0;
            pt_wr_q   <= 1'b0;
        end
        else
        begin
            mode_wr_q <= req_valid_q && req_write_q && (req_addr_q == MODE_ADDR);
            pt_wr_q   <= req_valid_q && req_write_q && (req_addr_q == PT_ADDR);
        end
    end

    always_ff @(posedge clk)
    begin
        wr_data_q <= req_data_q;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            vtp_mode      <= '0;
            pt_base       <= '0;
            pt_base_valid <= 1'b0;
        end
        else
        begin
            if (mode_wr_q)
                vtp_mode <= vtp_mode_t'(wr_data_q);
            // Page table base is a cache-line address, upper data bits drop off
            if (pt_wr_q)
            begin
                pt_base       <= pt_addr_t'(wr_data_q);
                pt_base_valid <= 1'b1;
            end
        end
    end

    // ======================================================================
    // Host reads
    // ======================================================================

    logic       rd_hit;
    mmio_addr_t rd_offset_full;
    logic       req_enq_en;
    req_entry_t req_enq_data;

    // Only reads that fall inside the manager window are queued
    assign rd_hit = req_valid_q && !req_write_q &&
                    (req_addr_q >= WIN_FIRST) && (req_addr_q < WIN_END);
    assign rd_offset_full = req_addr_q - WIN_FIRST;

    // One more register in front of the request queue
    always_ff @(posedge clk)
    begin
        if (reset)
            req_enq_en <= 1'b0;
        else
            req_enq_en <= rd_hit;
    end

    always_ff @(posedge clk)
    begin
        req_enq_data <= {csr_offset_t'(rd_offset_full), req_tid_q};
    end

    req_entry_t  req_head;
    csr_offset_t head_off;
    mmio_tid_t   head_tid;
    logic        req_rdy;
    logic        rsp_may_enq;
    logic        rsp_en;

    assign {head_off, head_tid} = req_head;

    // Decode and dequeue together whenever the response FIFO has room
    assign rsp_en = req_rdy && rsp_may_enq;

    mmio_fifo
    #(
        .payload_t(req_entry_t),
        .ENTRIES(64)
    )
    req_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_en(req_enq_en),
        .enq_data(req_enq_data),
        .deq_en(rsp_en),
        .first(req_head),
        .not_empty(req_rdy),
        .not_full()
    );

    mmio_data_t rsp_in_data;

    always_comb
    begin
        mmio_data_t  vtp_dfh;
        mmio_data_t  wro_dfh;
        feature_id_t vtp_id;
        feature_id_t wro_id;

        vtp_dfh = dfh_word(1'b0, dfh_next_t'(FEATURE_CSR_BYTES));

        // Write ordering closes the list unless another feature follows
        if (NEXT_ADDR == 0)
            wro_dfh = dfh_word(1'b1, dfh_next_t'(FEATURE_CSR_BYTES));
        else
            wro_dfh = dfh_word(1'b0, dfh_next_t'(NEXT_ADDR - WRO_BASE_BYTES));

        vtp_id = (ENABLE_VTP != 0) ? VTP_FEATURE_ID : '0;
        wro_id = (ENABLE_WRO != 0) ? WRO_FEATURE_ID : '0;

        // Unlisted offsets answer zero so every queued read gets a response
        case (head_off)
            OFF_VTP_DFH:  rsp_in_data = vtp_dfh;
            OFF_VTP_ID_L: rsp_in_data = vtp_id[63:0];
            OFF_VTP_ID_H: rsp_in_data = vtp_id[127:64];
            OFF_VTP_MODE: rsp_in_data = mmio_data_t'(vtp_mode);
            OFF_VTP_PT:   rsp_in_data = mmio_data_t'(pt_base);
            OFF_WRO_DFH:  rsp_in_data = wro_dfh;
            OFF_WRO_ID_L: rsp_in_data = wro_id[63:0];
            OFF_WRO_ID_H: rsp_in_data = wro_id[127:64];
            default:      rsp_in_data = '0;
        endcase
    end

    // ======================================================================
    // Response port
    // ======================================================================

    rsp_entry_t rsp_head;
    logic       rsp_rdy;
    logic       rsp_deq;

    mmio_fifo
    #(
        .payload_t(rsp_entry_t),
        .ENTRIES(2)
    )
    rsp_fifo
    (
        .clk(clk),
        .reset(reset),
        .enq_en(rsp_en),
        .enq_data({head_tid, rsp_in_data}),
        .deq_en(rsp_deq),
        .first(rsp_head),
        .not_empty(rsp_rdy),
        .not_full(rsp_may_enq)
    );

    // User block responses win; the manager waits in its FIFO
    assign rsp_deq = !afu_rsp_valid && rsp_rdy;

    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= afu_rsp_valid || rsp_rdy;
    end

    always_ff @(posedge clk)
    begin
        if (afu_rsp_valid)
            {rsp_tid, rsp_data} <= {afu_rsp_tid, afu_rsp_data};
        else if (rsp_deq)
            {rsp_tid, rsp_data} <= rsp_head;
    end

endmodule

// ==== verilog/mmio_shim_top.sv ====
/*
 * MMIO shim top, fans host requests out to the user scratch block and
 * the shim CSR manager
 */

`timescale 1ns/1ns

module mmio_shim_top
#(
    parameter int BASE_ADDR  = 256,
    parameter int NEXT_ADDR  = 0,
    parameter int ENABLE_VTP = 1,
    parameter int ENABLE_WRO = 1
)
(
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  logic                req_write,
    input  mmio_pkg::mmio_addr_t req_addr,
    input  mmio_pkg::mmio_tid_t  req_tid,
    input  mmio_pkg::mmio_data_t req_data,
    output logic                rsp_valid,
    output mmio_pkg::mmio_tid_t  rsp_tid,
    output mmio_pkg::mmio_data_t rsp_data,
    output mmio_pkg::vtp_mode_t  vtp_mode,
    output mmio_pkg::pt_addr_t   pt_base,
    output logic                pt_base_valid
);

    import mmio_pkg::*;

    // User block responses, merged by the manager
    logic       afu_rsp_valid;
    mmio_tid_t  afu_rsp_tid;
    mmio_data_t afu_rsp_data;

    afu_scratch_regs
    #(
        .BASE_ADDR(BASE_ADDR)
    )
    afu0
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_tid(req_tid),
        .req_data(req_data),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_tid(afu_rsp_tid),
        .afu_rsp_data(afu_rsp_data)
    );

    shim_csr_manager
    #(
        .BASE_ADDR(BASE_ADDR),
        .NEXT_ADDR(NEXT_ADDR),
        .ENABLE_VTP(ENABLE_VTP),
        .ENABLE_WRO(ENABLE_WRO)
    )
    csr0
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_tid(req_tid),
        .req_data(req_data),
        .afu_rsp_valid(afu_rsp_valid),
        .afu_rsp_tid(afu_rsp_tid),
        .afu_rsp_data(afu_rsp_data),
        .rsp_valid(rsp_valid),
        .rsp_tid(rsp_tid),
        .rsp_data(rsp_data),
        .vtp_mode(vtp_mode),
        .pt_base(pt_base),
        .pt_base_valid(pt_base_valid)
    );

endmodule

// ==== tb/mmio_model.svh ====
/*
 * Reference model of the MMIO shim register map, scratch contents and
 * outstanding reads, with typed compare tasks
 */

`ifndef MMIO_MODEL_SVH
`define MMIO_MODEL_SVH

// Expected register state, updated when a write is issued
mmio_data_t exp_scratch [SCRATCH_COUNT];
vtp_mode_t  exp_mode;
pt_addr_t   exp_pt;
logic       exp_pt_valid;

// Reads in flight, indexed by tag
logic       pending    [512];
logic       pend_afu   [512];
mmio_data_t pend_data  [512];
int         pend_cycle [512];
int         mgr_outstanding;
int         total_outstanding;

// ======================================================================
// Register map rules
// ======================================================================

task automatic reset_model();
    exp_scratch       = '{default: '0};
    pending           = '{default: 1'b0};
    exp_mode          = '0;
    exp_pt            = '0;
    exp_pt_valid      = 1'b0;
    mgr_outstanding   = 0;
    total_outstanding = 0;
endtask

// BBB header has type 2 at the top, end of list at bit 40 and next offset from bit 16
function automatic mmio_data_t header_value(input logic eol, input int next);
    return (64'h2 << 60) | (mmio_data_t'(eol) << 40) | (mmio_data_t'(next[23:0]) << 16);
endfunction

// Value of a manager window word, offset in 4-byte units from the window base
function automatic mmio_data_t window_value(input int off);
    logic [127:0] vtp_id;
    logic [127:0] wro_id;
    mmio_data_t   wro_hdr;

    vtp_id = (ENABLE_VTP != 0) ? VTP_FEATURE_ID : 128'h0;
    wro_id = (ENABLE_WRO != 0) ? WRO_FEATURE_ID : 128'h0;
    // The write-ordering header ends the list unless another feature follows
    if (NEXT_ADDR == 0)
        wro_hdr = header_value(1'b1, FEATURE_CSR_BYTES);
    else
        wro_hdr = header_value(1'b0, NEXT_ADDR - (BASE_ADDR + FEATURE_CSR_BYTES));
    case (off)
        0:       return header_value(1'b0, FEATURE_CSR_BYTES);
        2:       return vtp_id[63:0];
        4:       return vtp_id[127:64];
        6:       return mmio_data_t'(exp_mode);
        8:       return mmio_data_t'(exp_pt);
        // Second feature window starts 16 words in
        16:      return wro_hdr;
        18:      return wro_id[63:0];
        20:      return wro_id[127:64];
        default: return 64'h0;
    endcase
endfunction

task automatic apply_write(input int addr, input mmio_data_t data);
    if (addr < 2 * SCRATCH_COUNT && addr % 2 == 0)
        exp_scratch[addr[2:1]] = data;
    else if (addr == (BASE_ADDR + 24) / 4)
        exp_mode = data[1:0];
    else if (addr == (BASE_ADDR + 32) / 4)
    begin
        // Only the low 42 bits form the cache-line address
        exp_pt       = data[41:0];
        exp_pt_valid = 1'b1;
    end
endtask

// Reads outside both blocks are not recorded and must stay unanswered
task automatic expect_read(input mmio_tid_t tag, input int addr, input int now);
    logic owned;

    owned = 1'b1;
    if (addr < 2 * SCRATCH_COUNT && addr % 2 == 0)
    begin
        pend_afu[tag]  = 1'b1;
        pend_data[tag] = exp_scratch[addr[2:1]];
    end
    else if (addr >= BASE_ADDR / 4 && addr < (BASE_ADDR + 2 * FEATURE_CSR_BYTES) / 4)
    begin
        pend_afu[tag]  = 1'b0;
        pend_data[tag] = window_value(addr - BASE_ADDR / 4);
        mgr_outstanding++;
    end
    else
        owned = 1'b0;
    if (owned)
    begin
        pending[tag]    = 1'b1;
        pend_cycle[tag] = now;
        total_outstanding++;
    end
endtask

// ======================================================================
// Compare tasks
// ======================================================================

task automatic check_data(input string name, input mmio_data_t got, input mmio_data_t exp);
    if (got !== exp)
    begin
        $display("FAIL %s: got %h expected %h", name, got, exp);
        value_errors++;
    end
endtask

task automatic check_tid(input string name, input mmio_tid_t got, input mmio_tid_t exp);
    if (got !== exp)
    begin
        $display("FAIL %s: got %h expected %h", name, got, exp);
        value_errors++;
    end
endtask

task automatic check_mode(input string name, input vtp_mode_t got, input vtp_mode_t exp);
    if (got !== exp)
    begin
        $display("FAIL %s: got %h expected %h", name, got, exp);
        value_errors++;
    end
endtask

task automatic check_pt(input string name, input pt_addr_t got, input pt_addr_t exp);
    if (got !== exp)
    begin
        $display("FAIL %s: got %h expected %h", name, got, exp);
        value_errors++;
    end
endtask

`endif

// ==== tb/tb_mmio_shim.sv ====
/*
 * Testbench for the MMIO shim top, directed register checks and random
 * host traffic compared against a register map model
 */

`timescale 1ns/1ns

module tb_mmio_shim;

    import mmio_pkg::*;

    localparam int BASE_ADDR  = 256;
    localparam int NEXT_ADDR  = 0;
    localparam int ENABLE_VTP = 1;
    localparam int ENABLE_WRO = 0;

    // Word addresses of the manager window and its two writable registers
    localparam int WIN_FIRST = BASE_ADDR / 4;
    localparam int WIN_WORDS = 2 * FEATURE_CSR_BYTES / 4;
    localparam int MODE_WORD = (BASE_ADDR + 24) / 4;
    localparam int PT_WORD   = (BASE_ADDR + 32) / 4;

    localparam int RANDOM_OPS    = 500;
    localparam int MAX_MGR_READS = 48;
    localparam int DRAIN_LIMIT   = 2000;
    localparam int QUIET_CYCLES  = 100;

    logic       clk;
    logic       reset;
    logic       req_valid;
    logic       req_write;
    mmio_addr_t req_addr;
    mmio_tid_t  req_tid;
    mmio_data_t req_data;
    logic       rsp_valid;
    mmio_tid_t  rsp_tid;
    mmio_data_t rsp_data;
    vtp_mode_t  vtp_mode;
    pt_addr_t   pt_base;
    logic       pt_base_valid;

    int         value_errors;
    int         other_errors;
    int         cycle;
    mmio_tid_t  next_tag;
    mmio_tid_t  issued_tag;
    mmio_tid_t  last_tid;

    `include "mmio_model.svh"

    mmio_shim_top
    #(
        .BASE_ADDR(BASE_ADDR),
        .NEXT_ADDR(NEXT_ADDR),
        .ENABLE_VTP(ENABLE_VTP),
        .ENABLE_WRO(ENABLE_WRO)
    )
    dut0
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr(req_addr),
        .req_tid(req_tid),
        .req_data(req_data),
        .rsp_valid(rsp_valid),
        .rsp_tid(rsp_tid),
        .rsp_data(rsp_data),
        .vtp_mode(vtp_mode),
        .pt_base(pt_base),
        .pt_base_valid(pt_base_valid)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic note_failure(input string what);
        $display("ERROR at cycle %0d: %s", cycle, what);
        other_errors++;
    endtask

    // ======================================================================
    // Host request driver
    // ======================================================================

    // Drives one request on the falling edge; the next drive or release ends it
    task automatic issue_request(input logic is_write, input int addr, input mmio_data_t data);
        mmio_tid_t tag;

        tag      = next_tag;
        next_tag = next_tag + 9'd1;
        @(negedge clk);
        if (pending[tag])
            note_failure($sformatf("tag %h reused while its read is still outstanding", tag));
        req_valid  = 1'b1;
        req_write  = is_write;
        req_addr   = mmio_addr_t'(addr);
        req_tid    = tag;
        req_data   = data;
        issued_tag = tag;
        if (is_write)
            apply_write(addr, data);
        else
            expect_read(tag, addr, cycle);
    endtask

    task automatic release_bus();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
            release_bus();
    endtask

    task automatic drain_reads(input int limit);
        int waited;

        waited = 0;
        release_bus();
        while (total_outstanding > 0 && waited < limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (total_outstanding > 0)
            note_failure($sformatf("%0d reads got no response within %0d cycles",
                                   total_outstanding, limit));
    endtask

    // Keeps the manager request queue well below its 64 entries
    task automatic wait_for_room();
        int waited;

        waited = 0;
        release_bus();
        while (mgr_outstanding >= MAX_MGR_READS && waited < DRAIN_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (mgr_outstanding >= MAX_MGR_READS)
            note_failure("manager read queue did not drain in time");
    endtask

    task automatic read_and_check(input int addr);
        issue_request(1'b0, addr, 64'h0);
        drain_reads(DRAIN_LIMIT);
        check_tid("rsp_tid", last_tid, issued_tag);
    endtask

    // Register outputs change on the second rising edge after the sampling edge
    task automatic write_register_timed(input int addr, input mmio_data_t data);
        vtp_mode_t old_mode;
        pt_addr_t  old_pt;
        logic      old_valid;

        old_mode  = exp_mode;
        old_pt    = exp_pt;
        old_valid = exp_pt_valid;
        issue_request(1'b1, addr, data);
        release_bus();
        @(negedge clk);
        check_mode("vtp_mode", vtp_mode, old_mode);
        check_pt("pt_base", pt_base, old_pt);
        check_data("pt_base_valid", mmio_data_t'(pt_base_valid), mmio_data_t'(old_valid));
        @(negedge clk);
        check_mode("vtp_mode", vtp_mode, exp_mode);
        check_pt("pt_base", pt_base, exp_pt);
        check_data("pt_base_valid", mmio_data_t'(pt_base_valid), mmio_data_t'(exp_pt_valid));
    endtask

    // ======================================================================
    // Response monitor
    // ======================================================================

    // Outputs settle after the rising edge and are sampled on the falling one
    task automatic watch_responses();
        int lat;

        forever
        begin
            @(negedge clk);
            if (!reset && rsp_valid)
            begin
                last_tid = rsp_tid;
                lat      = cycle - pend_cycle[rsp_tid];
                if (!pending[rsp_tid])
                    note_failure($sformatf("response with tag %h matches no open read",
                                           rsp_tid));
                else
                begin
                    check_data("rsp_data", rsp_data, pend_data[rsp_tid]);
                    // Scratch reads take exactly two cycles, manager reads five or more
                    if (pend_afu[rsp_tid] && lat != 2)
                        note_failure($sformatf("scratch read %h answered after %0d cycles",
                                               rsp_tid, lat));
                    else if (!pend_afu[rsp_tid] && lat < 5)
                        note_failure($sformatf("manager read %h answered after only %0d cycles",
                                               rsp_tid, lat));
                    if (!pend_afu[rsp_tid])
                        mgr_outstanding--;
                    total_outstanding--;
                    pending[rsp_tid] = 1'b0;
                end
            end
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial
    begin
        int         i;
        int         kind;
        int         addr;
        logic       is_write;
        mmio_data_t data;

        void'($urandom(37014));
        value_errors = 0;
        other_errors = 0;
        cycle        = 0;
        next_tag     = '0;
        issued_tag   = '0;
        last_tid     = '0;
        reset        = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_tid      = '0;
        req_data     = '0;
        reset_model();
        fork
            watch_responses();
        join_none

        repeat (10)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Outputs idle after reset
        @(negedge clk);
        check_data("rsp_valid", mmio_data_t'(rsp_valid), 64'h0);
        check_data("pt_base_valid", mmio_data_t'(pt_base_valid), 64'h0);
        check_mode("vtp_mode", vtp_mode, 2'h0);
        check_pt("pt_base", pt_base, 42'h0);

        // Both headers and all ID words, end of list and the disabled ID included
        read_and_check(WIN_FIRST + 0);
        read_and_check(WIN_FIRST + 2);
        read_and_check(WIN_FIRST + 4);
        read_and_check(WIN_FIRST + 16);
        read_and_check(WIN_FIRST + 18);
        read_and_check(WIN_FIRST + 20);

        // Bit 0 set so both registers really move away from zero
        write_register_timed(MODE_WORD, {$urandom, $urandom} | 64'h1);
        read_and_check(MODE_WORD);
        write_register_timed(PT_WORD, {$urandom, $urandom} | 64'h1);
        read_and_check(PT_WORD);

        // Scratch writes, then back-to-back reads of all four
        for (i = 0; i < SCRATCH_COUNT; i++)
            issue_request(1'b1, 2 * i, {$urandom, $urandom});
        for (i = 0; i < SCRATCH_COUNT; i++)
            issue_request(1'b0, 2 * i, 64'h0);
        drain_reads(DRAIN_LIMIT);

        // Nobody owns these, the monitor flags any answer
        issue_request(1'b0, 1, 64'h0);
        issue_request(1'b0, 7, 64'h0);
        issue_request(1'b0, 8, 64'h0);
        issue_request(1'b0, WIN_FIRST - 1, 64'h0);
        issue_request(1'b0, WIN_FIRST + WIN_WORDS, 64'h0);
        issue_request(1'b0, 16'hffff, 64'h0);
        release_bus();
        repeat (QUIET_CYCLES)
            @(posedge clk);

        for (i = 0; i < RANDOM_OPS; i++)
        begin
            kind     = int'($urandom_range(99, 0));
            data     = {$urandom, $urandom};
            is_write = ($urandom_range(1, 0) == 1);
            if (kind < 30)
                addr = 2 * int'($urandom_range(SCRATCH_COUNT - 1, 0));
            else if (kind < 80)
            begin
                addr = WIN_FIRST + int'($urandom_range(WIN_WORDS - 1, 0));
                // Mostly reads here to keep the manager queue busy
                if (kind < 70)
                    is_write = 1'b0;
            end
            else if (kind < 88)
            begin
                addr     = ($urandom_range(1, 0) == 1) ? MODE_WORD : PT_WORD;
                is_write = 1'b1;
            end
            else if (kind < 93)
                addr = 2 * int'($urandom_range(SCRATCH_COUNT - 1, 0)) + 1;
            else if (kind < 97)
                addr = 8 + int'($urandom_range(WIN_FIRST - 9, 0));
            else
                addr = WIN_FIRST + WIN_WORDS + int'($urandom_range(200, 0));

            // A register write must not overtake queued reads of that register
            if (is_write && (addr == MODE_WORD || addr == PT_WORD))
                drain_reads(DRAIN_LIMIT);
            if (mgr_outstanding >= MAX_MGR_READS)
                wait_for_room();
            issue_request(is_write, addr, data);
            if ($urandom_range(3, 0) == 0)
                idle_cycles(int'($urandom_range(6, 1)));
        end
        drain_reads(DRAIN_LIMIT);

        check_mode("vtp_mode", vtp_mode, exp_mode);
        check_pt("pt_base", pt_base, exp_pt);
        check_data("pt_base_valid", mmio_data_t'(pt_base_valid), mmio_data_t'(exp_pt_valid));

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+tb
verilog/mmio_pkg.sv
verilog/mmio_fifo.sv
verilog/afu_scratch_regs.sv
verilog/shim_csr_manager.sv
verilog/mmio_shim_top.sv
tb/tb_mmio_shim.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the MMIO shim testbench with Verilator, runs it and scans the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_mmio_shim -f list.f -o tb_mmio_shim \
    && ./obj_dir/tb_mmio_shim | tee sim.log \
    || { echo "Simulation build or run failed"; exit 1; }
grep -q "FAIL: see errors above" sim.log \
    && { echo "Simulation reported failure"; exit 1; } \
    || { echo "Simulation finished without failure"; exit 0; }
